// File: execBackend.f
rtl/backendCfgPkg.sv
rtl/uopPkg.sv
rtl/issueDecode.sv
rtl/operandLoad.sv
rtl/intExec.sv
rtl/mulExec.sv
rtl/rfWriteback.sv
rtl/execBackend.sv
dv/execBackend_assertions.sv
dv/execBackendTb.sv

// File: dv/execBackendTb.sv
`timescale 1ns/1ps

module execBackendTb;
    localparam int DW = backendCfgPkg::DATA_W;
    localparam int TW = backendCfgPkg::TAG_W;
    localparam int SW = backendCfgPkg::SQN_W;
    localparam int NREG = backendCfgPkg::NUM_REGS;
    localparam int MUL_LATENCY = 3;
    localparam int MAX_ENTRIES = 32;
    localparam int TIMEOUT = 100;

    logic clk;
    logic rst;
    logic inValid;
    logic inReady;
    uopPkg::Opcode inOpcode;
    logic [TW-1:0] inTagA;
    logic [TW-1:0] inTagB;
    logic inImmB;
    logic [DW-1:0] inImm;
    logic [TW-1:0] inTagDst;
    logic [SW-1:0] inSqN;
    logic flush;
    logic [SW-1:0] flushSqN;
    logic intResValid;
    logic [TW-1:0] intResTag;
    logic [DW-1:0] intResData;
    logic [SW-1:0] intResSqN;
    logic mulResValid;
    logic [TW-1:0] mulResTag;
    logic [DW-1:0] mulResData;
    logic [SW-1:0] mulResSqN;

    // Stimulus table
    string stimName [MAX_ENTRIES];
    uopPkg::Opcode stimOp [MAX_ENTRIES];
    logic [TW-1:0] stimTagA [MAX_ENTRIES];
    logic [TW-1:0] stimTagB [MAX_ENTRIES];
    logic stimImmB [MAX_ENTRIES];
    logic [DW-1:0] stimImm [MAX_ENTRIES];
    logic [TW-1:0] stimTagDst [MAX_ENTRIES];
    logic [SW-1:0] stimSqN [MAX_ENTRIES];
    logic stimFlush [MAX_ENTRIES];
    logic [SW-1:0] stimFlushSqN [MAX_ENTRIES];
    logic stimBackToBack [MAX_ENTRIES];
    int nEntries;

    // Shadow registers and outstanding results, indexed by destination tag
    logic [DW-1:0] shadow [NREG];
    logic [DW-1:0] prevShadow [NREG];
    logic pending [NREG];
    string expName [NREG];
    logic [DW-1:0] expData [NREG];
    logic [SW-1:0] expSqN [NREG];
    int expCycle [NREG];
    int cycle = 0;
    int killCount = 0;
    int resCount = 0;
    int seed = 32'h3a0a9a9f;

    execBackend #(
        .MUL_LATENCY(MUL_LATENCY)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkResult(input string name, input logic [TW-1:0] tag,
                               input logic [DW-1:0] expVal, input logic [DW-1:0] actVal);
        if (actVal !== expVal)
            failRun($sformatf("ERR %s: tag %0d expected %h actual %h",
                              name, tag, expVal, actVal));
    endtask

    task automatic checkSqN(input string name, input logic [SW-1:0] expVal,
                            input logic [SW-1:0] actVal);
        if (actVal !== expVal)
            failRun($sformatf("ERR %s: sqN expected %0d actual %0d", name, expVal, actVal));
    endtask

    task automatic checkCycle(input string name, input int expVal, input int actVal);
        if (actVal != expVal)
            failRun($sformatf("ERR %s: arrival cycle expected %0d actual %0d",
                              name, expVal, actVal));
    endtask

    task automatic checkCount(input int expVal, input int actVal);
        if (actVal != expVal)
            failRun($sformatf("ERR result count: expected %0d actual %0d", expVal, actVal));
    endtask

    function automatic logic [DW-1:0] aluModel(input uopPkg::Opcode op,
                                               input logic [DW-1:0] a, input logic [DW-1:0] b);
        logic [2*DW-1:0] wide;
        wide = {{DW{1'b0}}, a} * {{DW{1'b0}}, b};
        case (op)
            uopPkg::OP_ADD:   return a + b;
            uopPkg::OP_SUB:   return a - b;
            uopPkg::OP_AND:   return a & b;
            uopPkg::OP_OR:    return a | b;
            uopPkg::OP_XOR:   return a ^ b;
            uopPkg::OP_SLL:   return a << b[4:0];
            uopPkg::OP_SRL:   return a >> b[4:0];
            uopPkg::OP_MUL:   return wide[DW-1:0];
            uopPkg::OP_MULHU: return wide[2*DW-1:DW];
            default:          return '0;
        endcase
    endfunction

    function automatic int latencyOf(input uopPkg::Opcode op);
        if (uopPkg::unitOf(op) == uopPkg::FU_MUL)
            return 2 + MUL_LATENCY;
        return 3;
    endfunction

    // Positive wrapped difference means younger
    function automatic bit younger(input logic [SW-1:0] sqN, input logic [SW-1:0] refSqN);
        logic signed [SW-1:0] diff;
        diff = sqN - refSqN;
        return diff > 0;
    endfunction

    function automatic void addEntry(input string name, input uopPkg::Opcode op,
                                     input logic [TW-1:0] tagA, input logic [TW-1:0] tagB,
                                     input logic immB, input logic [DW-1:0] imm,
                                     input logic [TW-1:0] tagDst);
        stimName[nEntries] = name;
        stimOp[nEntries] = op;
        stimTagA[nEntries] = tagA;
        stimTagB[nEntries] = tagB;
        stimImmB[nEntries] = immB;
        stimImm[nEntries] = imm;
        stimTagDst[nEntries] = tagDst;
        stimSqN[nEntries] = nEntries + 1;
        stimFlush[nEntries] = 1'b0;
        stimFlushSqN[nEntries] = '0;
        stimBackToBack[nEntries] = 1'b0;
        nEntries++;
    endfunction

    task automatic buildTable();
        logic [SW-1:0] keepSq;
        nEntries = 0;
        addEntry("add imm", uopPkg::OP_ADD, 0, 0, 1, $random(seed), 1);
        addEntry("or imm", uopPkg::OP_OR, 0, 0, 1, $random(seed), 2);
        addEntry("xor imm", uopPkg::OP_XOR, 0, 0, 1, $random(seed), 3);
        addEntry("sub imm", uopPkg::OP_SUB, 0, 0, 1, $random(seed), 4);
        addEntry("sll imm", uopPkg::OP_SLL, 0, 0, 1, $random(seed), 5);
        // Each link reads the one before it
        addEntry("chain add", uopPkg::OP_ADD, 1, 2, 0, 0, 10);
        addEntry("chain sub", uopPkg::OP_SUB, 10, 3, 0, 0, 11);
        addEntry("chain sll", uopPkg::OP_SLL, 11, 0, 1, $random(seed), 12);
        addEntry("chain srl", uopPkg::OP_SRL, 12, 0, 1, $random(seed), 13);
        addEntry("chain and", uopPkg::OP_AND, 13, 4, 0, 0, 14);
        addEntry("chain xor", uopPkg::OP_XOR, 14, 11, 0, 0, 15);
        addEntry("mul low", uopPkg::OP_MUL, 15, 2, 0, 0, 20);
        addEntry("mul high", uopPkg::OP_MULHU, 15, 2, 0, 0, 21);
        addEntry("add after mul", uopPkg::OP_ADD, 21, 20, 0, 0, 22);
        // Int result lands in the same cycle as the second multiply
        addEntry("mul stream a", uopPkg::OP_MUL, 1, 2, 0, 0, 23);
        addEntry("mul stream b", uopPkg::OP_MULHU, 3, 1, 0, 0, 24);
        addEntry("mul stream c", uopPkg::OP_MUL, 2, 3, 0, 0, 25);
        addEntry("int beside mul", uopPkg::OP_XOR, 1, 3, 0, 0, 26);
        for (int k = nEntries - 4; k < nEntries; k++)
            stimBackToBack[k] = 1'b1;
        keepSq = nEntries + 1;
        addEntry("flush keep", uopPkg::OP_MUL, 1, 2, 0, 0, 30);
        addEntry("flush mul", uopPkg::OP_MULHU, 2, 3, 0, 0, 31);
        addEntry("flush int", uopPkg::OP_ADD, 1, 0, 1, $random(seed), 32);
        stimFlush[nEntries-1] = 1'b1;
        stimFlushSqN[nEntries-1] = keepSq;
        addEntry("reuse 31", uopPkg::OP_ADD, 1, 2, 0, 0, 31);
        addEntry("reuse 32", uopPkg::OP_SUB, 3, 1, 0, 0, 32);
        addEntry("after reuse", uopPkg::OP_XOR, 31, 32, 0, 0, 33);
    endtask

    task automatic issueEntry(input int i);
        logic [DW-1:0] srcA;
        logic [DW-1:0] srcB;
        logic [DW-1:0] result;
        logic [TW-1:0] dst;
        int waited;
        int acceptCycle;
        srcA = shadow[stimTagA[i]];
        srcB = stimImmB[i] ? stimImm[i] : shadow[stimTagB[i]];
        result = aluModel(stimOp[i], srcA, srcB);
        dst = stimTagDst[i];
        inValid = 1'b1;
        inOpcode = stimOp[i];
        inTagA = stimTagA[i];
        inTagB = stimTagB[i];
        inImmB = stimImmB[i];
        inImm = stimImm[i];
        inTagDst = dst;
        inSqN = stimSqN[i];
        waited = 0;
        @(negedge clk);
        while (!inReady) begin
            // Its sources and destination are free, so any stall is wrong
            if (stimBackToBack[i])
                failRun($sformatf("%s was stalled although its tags were free",
                                  stimName[i]));
            waited++;
            if (waited > TIMEOUT)
                failRun($sformatf("%s was never accepted, inReady stayed low", stimName[i]));
            @(negedge clk);
        end
        acceptCycle = cycle + 1;
        @(posedge clk);
        pending[dst] = 1'b1;
        expName[dst] = stimName[i];
        expData[dst] = result;
        expSqN[dst] = stimSqN[i];
        expCycle[dst] = acceptCycle + latencyOf(stimOp[i]);
        prevShadow[dst] = shadow[dst];
        shadow[dst] = result;
        #1;
        inValid = 1'b0;
    endtask

    task automatic applyFlush(input logic [SW-1:0] refSqN);
        flush = 1'b1;
        flushSqN = refSqN;
        // Younger ops in flight never write their register
        for (int t = 1; t < NREG; t++) begin
            if (pending[t] && younger(expSqN[t], refSqN)) begin
                pending[t] = 1'b0;
                shadow[t] = prevShadow[t];
                killCount++;
            end
        end
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic takeResult(input logic [TW-1:0] tag, input logic [DW-1:0] data,
                              input logic [SW-1:0] sqN);
        if (!pending[tag]) begin
            failRun($sformatf("a result on tag %0d arrived with no micro-op outstanding", tag));
        end else begin
            checkResult(expName[tag], tag, expData[tag], data);
            checkSqN(expName[tag], expSqN[tag], sqN);
            checkCycle(expName[tag], expCycle[tag], cycle);
            pending[tag] = 1'b0;
            resCount++;
        end
    endtask

    // Result monitor, both ports can fire together
    initial begin
        forever begin
            @(negedge clk);
            if (rst === 1'b0) begin
                if (intResValid === 1'b1)
                    takeResult(intResTag, intResData, intResSqN);
                if (mulResValid === 1'b1)
                    takeResult(mulResTag, mulResData, mulResSqN);
            end
        end
    end

    initial begin
        int waited;
        rst = 1'b1;
        inValid = 1'b0;
        inOpcode = uopPkg::OP_ADD;
        inTagA = '0;
        inTagB = '0;
        inImmB = 1'b0;
        inImm = '0;
        inTagDst = '0;
        inSqN = '0;
        flush = 1'b0;
        flushSqN = '0;
        for (int t = 0; t < NREG; t++) begin
            shadow[t] = '0;
            prevShadow[t] = '0;
            pending[t] = 1'b0;
        end
        buildTable();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < nEntries; i++) begin
            issueEntry(i);
            if (stimFlush[i])
                applyFlush(stimFlushSqN[i]);
        end
        // Missing results show up as a short count below
        waited = 0;
        while (resCount < nEntries - killCount && waited <= TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        // Any late result from a killed op shows up here
        repeat (8) @(posedge clk);
        checkCount(nEntries - killCount, resCount);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: dv/execBackend_assertions.sv
`timescale 1ns/1ps

module execBackend_assertions (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                inValid,
    input  logic                                inReady,
    input  uopPkg::Opcode                       inOpcode,
    input  logic [backendCfgPkg::TAG_W-1:0]     inTagA,
    input  logic [backendCfgPkg::TAG_W-1:0]     inTagB,
    input  logic                                inImmB,
    input  logic [backendCfgPkg::DATA_W-1:0]    inImm,
    input  logic [backendCfgPkg::TAG_W-1:0]     inTagDst,
    input  logic [backendCfgPkg::SQN_W-1:0]     inSqN,
    input  logic                                decValid,
    input  uopPkg::Opcode                       decOpcode,
    input  logic                                intEnable,
    input  logic                                mulEnable,
    input  logic                                intResValid,
    input  logic                                mulResValid
);
    // A decoded micro-op enables exactly the unit its opcode belongs to
    assert property (@(posedge clk) disable iff (rst)
        decValid |=> intEnable != mulEnable &&
            mulEnable == ($past(decOpcode) inside {uopPkg::OP_MUL, uopPkg::OP_MULHU}))
        else $error("unit enables do not match the decoded opcode");

    // No enable without a decoded micro-op
    assert property (@(posedge clk) disable iff (rst)
        !decValid |=> !intEnable && !mulEnable)
        else $error("a unit enable is high with no decoded micro-op");

    // A stalled micro-op is held by the producer
    assert property (@(posedge clk) disable iff (rst)
        inValid && !inReady |=> inValid && $stable(inOpcode) && $stable(inTagA) &&
            $stable(inTagB) && $stable(inImmB) && $stable(inImm) &&
            $stable(inTagDst) && $stable(inSqN))
        else $error("input micro-op changed while inReady was low");

    assert property (@(posedge clk) rst |=> !intResValid && !mulResValid)
        else $error("a result valid is high in the cycle after reset");

endmodule

bind execBackend execBackend_assertions u_assertions (.*);

// File: rtl/execBackend.sv
`timescale 1ns/1ps

module execBackend #(
    parameter int MUL_LATENCY = 3
) (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                inValid,
    output logic                                inReady,
    input  uopPkg::Opcode                       inOpcode,
    input  logic [backendCfgPkg::TAG_W-1:0]     inTagA,
    input  logic [backendCfgPkg::TAG_W-1:0]     inTagB,
    input  logic                                inImmB,
    input  logic [backendCfgPkg::DATA_W-1:0]    inImm,
    input  logic [backendCfgPkg::TAG_W-1:0]     inTagDst,
    input  logic [backendCfgPkg::SQN_W-1:0]     inSqN,

    input  logic                                flush,
    input  logic [backendCfgPkg::SQN_W-1:0]     flushSqN,

    output logic                                intResValid,
    output logic [backendCfgPkg::TAG_W-1:0]     intResTag,
    output logic [backendCfgPkg::DATA_W-1:0]    intResData,
    output logic [backendCfgPkg::SQN_W-1:0]     intResSqN,
    output logic                                mulResValid,
    output logic [backendCfgPkg::TAG_W-1:0]     mulResTag,
    output logic [backendCfgPkg::DATA_W-1:0]    mulResData,
    output logic [backendCfgPkg::SQN_W-1:0]     mulResSqN
);
    localparam int DW = backendCfgPkg::DATA_W;
    localparam int TW = backendCfgPkg::TAG_W;
    localparam int SW = backendCfgPkg::SQN_W;

    // Decode to load
    logic decValid, decKill, decImmB;
    uopPkg::FuncUnit decUnit;
    uopPkg::Opcode decOpcode;
    logic [TW-1:0] decTagA, decTagB, decTagDst;
    logic [DW-1:0] decImm;
    logic [SW-1:0] decSqN;

    // Register file read
    logic [TW-1:0] rfAddrA, rfAddrB;
    logic [DW-1:0] rfDataA, rfDataB;

    // Load to execution units
    logic intEnable, mulEnable, exKill;
    uopPkg::Opcode exOpcode;
    logic [DW-1:0] exSrcA, exSrcB;
    logic [TW-1:0] exTagDst;
    logic [SW-1:0] exSqN;

    // Writeback buses
    logic intWbValid, intWbKill, mulWbValid, mulWbKill;
    logic [TW-1:0] intWbTag, mulWbTag;
    logic [DW-1:0] intWbData, mulWbData;
    logic [SW-1:0] intWbSqN, mulWbSqN;

    issueDecode u_decode (.*);

    operandLoad u_load (.*);

    intExec u_int (.*);

    mulExec #(
        .MUL_LATENCY(MUL_LATENCY)
    ) u_mul (.*);

    rfWriteback u_wb (.*);

endmodule

// File: rtl/rfWriteback.sv
`timescale 1ns/1ps

module rfWriteback (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [backendCfgPkg::TAG_W-1:0]     rfAddrA,
    input  logic [backendCfgPkg::TAG_W-1:0]     rfAddrB,
    output logic [backendCfgPkg::DATA_W-1:0]    rfDataA,
    output logic [backendCfgPkg::DATA_W-1:0]    rfDataB,

    input  logic                                intWbValid,
    input  logic                                intWbKill,
    input  logic [backendCfgPkg::TAG_W-1:0]     intWbTag,
    input  logic [backendCfgPkg::DATA_W-1:0]    intWbData,
    input  logic [backendCfgPkg::SQN_W-1:0]     intWbSqN,
    input  logic                                mulWbValid,
    input  logic                                mulWbKill,
    input  logic [backendCfgPkg::TAG_W-1:0]     mulWbTag,
    input  logic [backendCfgPkg::DATA_W-1:0]    mulWbData,
    input  logic [backendCfgPkg::SQN_W-1:0]     mulWbSqN,

    output logic                                intResValid,
    output logic [backendCfgPkg::TAG_W-1:0]     intResTag,
    output logic [backendCfgPkg::DATA_W-1:0]    intResData,
    output logic [backendCfgPkg::SQN_W-1:0]     intResSqN,
    output logic                                mulResValid,
    output logic [backendCfgPkg::TAG_W-1:0]     mulResTag,
    output logic [backendCfgPkg::DATA_W-1:0]    mulResData,
    output logic [backendCfgPkg::SQN_W-1:0]     mulResSqN
);
    logic [backendCfgPkg::DATA_W-1:0] regs [backendCfgPkg::NUM_REGS];
    logic intLive;
    logic mulLive;

    assign intLive = intWbValid && !intWbKill;
    assign mulLive = mulWbValid && !mulWbKill;

    // Tag 0 is hardwired to zero
    assign rfDataA = (rfAddrA == '0) ? '0 : regs[rfAddrA];
    assign rfDataB = (rfAddrB == '0) ? '0 : regs[rfAddrB];

    always_ff @(posedge clk) begin
        if (intLive && intWbTag != '0)
            regs[intWbTag] <= intWbData;
        if (mulLive && mulWbTag != '0)
            regs[mulWbTag] <= mulWbData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            intResValid <= 1'b0;
            mulResValid <= 1'b0;
        end else begin
            intResValid <= intLive;
            mulResValid <= mulLive;
        end
    end

    always_ff @(posedge clk) begin
        intResTag <= intWbTag;
        intResData <= intWbData;
        intResSqN <= intWbSqN;
        mulResTag <= mulWbTag;
        mulResData <= mulWbData;
        mulResSqN <= mulWbSqN;
    end

endmodule

// File: rtl/mulExec.sv
`timescale 1ns/1ps

module mulExec #(
    parameter int MUL_LATENCY = 3
) (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                mulEnable,
    input  logic                                exKill,
    input  uopPkg::Opcode                       exOpcode,
    input  logic [backendCfgPkg::DATA_W-1:0]    exSrcA,
    input  logic [backendCfgPkg::DATA_W-1:0]    exSrcB,
    input  logic [backendCfgPkg::TAG_W-1:0]     exTagDst,
    input  logic [backendCfgPkg::SQN_W-1:0]     exSqN,

    input  logic                                flush,
    input  logic [backendCfgPkg::SQN_W-1:0]     flushSqN,

    output logic                                mulWbValid,
    output logic                                mulWbKill,
    output logic [backendCfgPkg::TAG_W-1:0]     mulWbTag,
    output logic [backendCfgPkg::DATA_W-1:0]    mulWbData,
    output logic [backendCfgPkg::SQN_W-1:0]     mulWbSqN
);
    localparam int W = backendCfgPkg::DATA_W;

    logic [2*W-1:0] product;
    logic [W-1:0] productWord;
    logic [MUL_LATENCY-1:0] stValid;
    logic [MUL_LATENCY-1:0] stKill;
    logic [W-1:0] stData [MUL_LATENCY];
    logic [backendCfgPkg::TAG_W-1:0] stTag [MUL_LATENCY];
    logic [backendCfgPkg::SQN_W-1:0] stSqN [MUL_LATENCY];

    // Unsigned product, word picked by opcode
    assign product = exSrcA * exSrcB;
    assign productWord = (exOpcode == uopPkg::OP_MULHU) ? product[2*W-1:W] : product[W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            stValid <= '0;
            stKill <= '0;
        end else begin
            stValid[0] <= mulEnable;
            stKill[0] <= exKill || (flush && backendCfgPkg::isYounger(exSqN, flushSqN));
            for (int i = 1; i < MUL_LATENCY; i++) begin
                stValid[i] <= stValid[i-1];
                stKill[i] <= stKill[i-1] ||
                             (flush && backendCfgPkg::isYounger(stSqN[i-1], flushSqN));
            end
        end
    end

    always_ff @(posedge clk) begin
        stData[0] <= productWord;
        stTag[0] <= exTagDst;
        stSqN[0] <= exSqN;
        for (int i = 1; i < MUL_LATENCY; i++) begin
            stData[i] <= stData[i-1];
            stTag[i] <= stTag[i-1];
            stSqN[i] <= stSqN[i-1];
        end
    end

    assign mulWbValid = stValid[MUL_LATENCY-1];
    assign mulWbKill = stKill[MUL_LATENCY-1];
    assign mulWbTag = stTag[MUL_LATENCY-1];
    assign mulWbData = stData[MUL_LATENCY-1];
    assign mulWbSqN = stSqN[MUL_LATENCY-1];

endmodule

// File: rtl/intExec.sv
`timescale 1ns/1ps

module intExec (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                intEnable,
    input  logic                                exKill,
    input  uopPkg::Opcode                       exOpcode,
    input  logic [backendCfgPkg::DATA_W-1:0]    exSrcA,
    input  logic [backendCfgPkg::DATA_W-1:0]    exSrcB,
    input  logic [backendCfgPkg::TAG_W-1:0]     exTagDst,
    input  logic [backendCfgPkg::SQN_W-1:0]     exSqN,

    input  logic                                flush,
    input  logic [backendCfgPkg::SQN_W-1:0]     flushSqN,

    output logic                                intWbValid,
    output logic                                intWbKill,
    output logic [backendCfgPkg::TAG_W-1:0]     intWbTag,
    output logic [backendCfgPkg::DATA_W-1:0]    intWbData,
    output logic [backendCfgPkg::SQN_W-1:0]     intWbSqN
);
    logic [backendCfgPkg::DATA_W-1:0] aluOut;

    always_comb begin
        case (exOpcode)
            uopPkg::OP_ADD: aluOut = exSrcA + exSrcB;
            uopPkg::OP_SUB: aluOut = exSrcA - exSrcB;
            uopPkg::OP_AND: aluOut = exSrcA & exSrcB;
            uopPkg::OP_OR:  aluOut = exSrcA | exSrcB;
            uopPkg::OP_XOR: aluOut = exSrcA ^ exSrcB;
            uopPkg::OP_SLL: aluOut = exSrcA << exSrcB[4:0];
            uopPkg::OP_SRL: aluOut = exSrcA >> exSrcB[4:0];
            default:        aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            intWbValid <= 1'b0;
            intWbKill <= 1'b0;
        end else begin
            intWbValid <= intEnable;
            intWbKill <= exKill || (flush && backendCfgPkg::isYounger(exSqN, flushSqN));
        end
    end

    always_ff @(posedge clk) begin
        intWbTag <= exTagDst;
        intWbData <= aluOut;
        intWbSqN <= exSqN;
    end

endmodule

// File: rtl/operandLoad.sv
`timescale 1ns/1ps

module operandLoad (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                decValid,
    input  logic                                decKill,
    input  uopPkg::FuncUnit                     decUnit,
    input  uopPkg::Opcode                       decOpcode,
    input  logic [backendCfgPkg::TAG_W-1:0]     decTagA,
    input  logic [backendCfgPkg::TAG_W-1:0]     decTagB,
    input  logic                                decImmB,
    input  logic [backendCfgPkg::DATA_W-1:0]    decImm,
    input  logic [backendCfgPkg::TAG_W-1:0]     decTagDst,
    input  logic [backendCfgPkg::SQN_W-1:0]     decSqN,

    input  logic                                flush,
    input  logic [backendCfgPkg::SQN_W-1:0]     flushSqN,

    output logic [backendCfgPkg::TAG_W-1:0]     rfAddrA,
    output logic [backendCfgPkg::TAG_W-1:0]     rfAddrB,
    input  logic [backendCfgPkg::DATA_W-1:0]    rfDataA,
    input  logic [backendCfgPkg::DATA_W-1:0]    rfDataB,

    input  logic                                intWbValid,
    input  logic                                intWbKill,
    input  logic [backendCfgPkg::TAG_W-1:0]     intWbTag,
    input  logic [backendCfgPkg::DATA_W-1:0]    intWbData,
    input  logic                                mulWbValid,
    input  logic                                mulWbKill,
    input  logic [backendCfgPkg::TAG_W-1:0]     mulWbTag,
    input  logic [backendCfgPkg::DATA_W-1:0]    mulWbData,

    output logic                                intEnable,
    output logic                                mulEnable,
    output logic                                exKill,
    output uopPkg::Opcode                       exOpcode,
    output logic [backendCfgPkg::DATA_W-1:0]    exSrcA,
    output logic [backendCfgPkg::DATA_W-1:0]    exSrcB,
    output logic [backendCfgPkg::TAG_W-1:0]     exTagDst,
    output logic [backendCfgPkg::SQN_W-1:0]     exSqN
);
    logic [backendCfgPkg::DATA_W-1:0] srcA;
    logic [backendCfgPkg::DATA_W-1:0] srcB;
    logic loadHit;

    assign rfAddrA = decTagA;
    assign rfAddrB = decTagB;

    // Snoop live writebacks, register file otherwise
    function automatic logic [backendCfgPkg::DATA_W-1:0] snoop(
        input logic [backendCfgPkg::TAG_W-1:0] tag,
        input logic [backendCfgPkg::DATA_W-1:0] rfData
    );
        if (tag != '0 && intWbValid && !intWbKill && intWbTag == tag)
            return intWbData;
        if (tag != '0 && mulWbValid && !mulWbKill && mulWbTag == tag)
            return mulWbData;
        return rfData;
    endfunction

    always_comb begin
        srcA = snoop(decTagA, rfDataA);
        srcB = decImmB ? decImm : snoop(decTagB, rfDataB);
    end

    assign loadHit = flush && backendCfgPkg::isYounger(decSqN, flushSqN);

    always_ff @(posedge clk) begin
        if (rst) begin
            intEnable <= 1'b0;
            mulEnable <= 1'b0;
            exKill <= 1'b0;
        end else begin
            // Killed ops still go through so the scoreboard clears
            intEnable <= decValid && decUnit == uopPkg::FU_INT;
            mulEnable <= decValid && decUnit == uopPkg::FU_MUL;
            exKill <= decKill || loadHit;
        end
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            exOpcode <= decOpcode;
            exSrcA <= srcA;
            exSrcB <= srcB;
            exTagDst <= decTagDst;
            exSqN <= decSqN;
        end
    end

endmodule

// File: rtl/issueDecode.sv
`timescale 1ns/1ps

module issueDecode (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                inValid,
    output logic                                inReady,
    input  uopPkg::Opcode                       inOpcode,
    input  logic [backendCfgPkg::TAG_W-1:0]     inTagA,
    input  logic [backendCfgPkg::TAG_W-1:0]     inTagB,
    input  logic                                inImmB,
    input  logic [backendCfgPkg::DATA_W-1:0]    inImm,
    input  logic [backendCfgPkg::TAG_W-1:0]     inTagDst,
    input  logic [backendCfgPkg::SQN_W-1:0]     inSqN,

    input  logic                                flush,
    input  logic [backendCfgPkg::SQN_W-1:0]     flushSqN,

    input  logic                                intWbValid,
    input  logic [backendCfgPkg::TAG_W-1:0]     intWbTag,
    input  logic                                mulWbValid,
    input  logic [backendCfgPkg::TAG_W-1:0]     mulWbTag,

    output logic                                decValid,
    output logic                                decKill,
    output uopPkg::FuncUnit                     decUnit,
    output uopPkg::Opcode                       decOpcode,
    output logic [backendCfgPkg::TAG_W-1:0]     decTagA,
    output logic [backendCfgPkg::TAG_W-1:0]     decTagB,
    output logic                                decImmB,
    output logic [backendCfgPkg::DATA_W-1:0]    decImm,
    output logic [backendCfgPkg::TAG_W-1:0]     decTagDst,
    output logic [backendCfgPkg::SQN_W-1:0]     decSqN
);
    logic [backendCfgPkg::NUM_REGS-1:0] busy;
    logic srcAReady;
    logic srcBReady;
    logic flushRefuse;
    logic accept;

    // A source completing on either bus this cycle counts as ready
    assign srcAReady = inTagA == '0 || !busy[inTagA] ||
                       (intWbValid && intWbTag == inTagA) || (mulWbValid && mulWbTag == inTagA);
    assign srcBReady = inImmB || inTagB == '0 || !busy[inTagB] ||
                       (intWbValid && intWbTag == inTagB) || (mulWbValid && mulWbTag == inTagB);

    assign flushRefuse = flush && backendCfgPkg::isYounger(inSqN, flushSqN);
    assign inReady = srcAReady && srcBReady && !busy[inTagDst] && !flushRefuse;
    assign accept = inValid && inReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            decValid <= 1'b0;
        end else begin
            if (intWbValid)
                busy[intWbTag] <= 1'b0;
            if (mulWbValid)
                busy[mulWbTag] <= 1'b0;
            // Tag 0 is never written, so it is never tracked
            if (accept && inTagDst != '0)
                busy[inTagDst] <= 1'b1;
            decValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            decUnit <= uopPkg::unitOf(inOpcode);
            decOpcode <= inOpcode;
            decTagA <= inTagA;
            decTagB <= inTagB;
            decImmB <= inImmB;
            decImm <= inImm;
            decTagDst <= inTagDst;
            decSqN <= inSqN;
        end
    end

    assign decKill = decValid && flush && backendCfgPkg::isYounger(decSqN, flushSqN);

endmodule

// File: rtl/uopPkg.sv
package uopPkg;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_MUL,
        OP_MULHU
    } Opcode;

    typedef enum logic {
        FU_INT,
        FU_MUL
    } FuncUnit;

    // Multiplies go to the multiplier, everything else to the ALU
    function automatic FuncUnit unitOf(input Opcode op);
        if (op == OP_MUL || op == OP_MULHU)
            return FU_MUL;
        return FU_INT;
    endfunction

endpackage

// File: rtl/backendCfgPkg.sv
package backendCfgPkg;

    // Operand and result width
    localparam int DATA_W = 32;

    // Physical register tags
    localparam int TAG_W = 6;
    localparam int NUM_REGS = 1 << TAG_W;

    // Sequence numbers wrap, so age comes from the signed difference
    localparam int SQN_W = 6;

    function automatic logic isYounger(input logic [SQN_W-1:0] sqN,
                                       input logic [SQN_W-1:0] refSqN);
        return $signed(sqN - refSqN) > 0;
    endfunction

endpackage
